/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --timescale 1ns/100ps
TOP      := tb_fetch_unit
FILELIST := compile.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the simulator output
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    // 4 ns period, so each half lasts 2 ns
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset spans three rising edges and lifts 1 ns after the third one
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

/* bench/tb_fetch_unit.sv */
`timescale 1ns/100ps

module tb_fetch_unit;

    localparam int               QUEUE_DEPTH = 8;
    localparam fetch_pkg::addr_t RESET_PC    = 32'h0000_0100;
    // the stall phase fetches from its own window so its acks can be counted
    localparam fetch_pkg::addr_t STALL_PC    = 32'h0000_1000;
    localparam int N_SEQ   = 80;
    localparam int N_RAND  = 100;
    localparam int N_REDIR = 6;
    localparam int N_AFTER = 8;
    localparam int TOTAL_WORDS = N_SEQ + N_RAND + QUEUE_DEPTH + 1 + N_REDIR * N_AFTER;
    localparam int WATCHDOG_CYCLES = 20 * TOTAL_WORDS * 8;

    logic               clk;
    logic               rst_n;
    fetch_pkg::wb_req_t wb_req;
    fetch_pkg::wb_rsp_t wb_rsp;
    logic               redirect_valid;
    fetch_pkg::addr_t   redirect_pc;
    logic               dec_valid;
    isa_pkg::decoded_t  dec;
    logic               dec_ready;

    int errors = 0;
    int n_dec = 0;
    int stall_acks = 0;
    int n_reg = 0;
    int n_imm = 0;
    int n_br = 0;
    // pc the next decoded word must carry
    fetch_pkg::addr_t  exp_pc = RESET_PC;
    isa_pkg::decoded_t exp_dec;

    tb_clock i_clock (
        .clk  (clk),
        .rst_n(rst_n)
    );

    wb_memory_model i_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp)
    );

    fetch_unit_top #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .RESET_PC   (RESET_PC)
    ) i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .wb_req        (wb_req),
        .wb_rsp        (wb_rsp),
        .redirect_valid(redirect_valid),
        .redirect_pc   (redirect_pc),
        .dec_valid     (dec_valid),
        .dec           (dec),
        .dec_ready     (dec_ready)
    );

    // top six bits are the opcode, bit 31 selects immediate format, bits 31 and 30 a branch
    function automatic isa_pkg::decoded_t expected_decode(fetch_pkg::addr_t pc);
        logic [31:0]       w;
        isa_pkg::decoded_t d;
        w           = i_mem.mem_word(pc);
        d.pc        = pc;
        d.opcode    = w[31:26];
        d.is_imm    = w[31];
        d.is_branch = w[31] & w[30];
        d.rd        = w[25:21];
        d.rs1       = w[20:16];
        d.raw       = w[22:0];
        if (d.is_imm) begin
            d.rs2   = '0;
            d.funct = '0;
            d.imm   = {{16{w[15]}}, w[15:0]};
        end else begin
            d.rs2   = w[15:11];
            d.funct = w[10:0];
            d.imm   = '0;
        end
        return d;
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, want);
        end
    endtask

    // inputs change 1 ns after the rising edge, well clear of it
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // a one-cycle redirect pulse
    task automatic send_redirect(fetch_pkg::addr_t target);
        redirect_valid = 1'b1;
        redirect_pc    = target;
        next_cycle();
        redirect_valid = 1'b0;
    endtask

    task automatic wait_words(int target);
        while (n_dec < target) begin
            next_cycle();
        end
    endtask

    // every transfer at the decode port is checked field by field
    initial begin
        forever begin
            @(posedge clk);
            if (rst_n && dec_valid && dec_ready) begin
                exp_dec = expected_decode(exp_pc);
                check_value("dec.pc", dec.pc, exp_dec.pc);
                check_value("dec.opcode", 32'(dec.opcode), 32'(exp_dec.opcode));
                check_value("dec.is_imm", 32'(dec.is_imm), 32'(exp_dec.is_imm));
                check_value("dec.is_branch", 32'(dec.is_branch), 32'(exp_dec.is_branch));
                check_value("dec.rd", 32'(dec.rd), 32'(exp_dec.rd));
                check_value("dec.rs1", 32'(dec.rs1), 32'(exp_dec.rs1));
                check_value("dec.rs2", 32'(dec.rs2), 32'(exp_dec.rs2));
                check_value("dec.funct", 32'(dec.funct), 32'(exp_dec.funct));
                check_value("dec.imm", dec.imm, exp_dec.imm);
                check_value("dec.raw", 32'(dec.raw), 32'(exp_dec.raw));
                // the formats are counted as the DUT flags them
                if (dec.is_branch) begin
                    n_br++;
                end
                if (dec.is_imm) begin
                    n_imm++;
                end else begin
                    n_reg++;
                end
                exp_pc = exp_pc + 32'd4;
                n_dec++;
            end
            // a word taken in the redirect cycle still belongs to the old stream
            if (rst_n && redirect_valid) begin
                exp_pc = redirect_pc;
            end
            if (wb_req.cyc && wb_rsp.ack && wb_req.adr >= STALL_PC
                    && wb_req.adr < STALL_PC + 32'h400) begin
                stall_acks++;
            end
        end
    end

    initial begin
        int base;
        void'($urandom(43));
        dec_ready      = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;

        // the bus and the decode port stay quiet in reset
        next_cycle();
        check_value("wb_req.cyc", 32'(wb_req.cyc), 32'd0);
        check_value("wb_req.stb", 32'(wb_req.stb), 32'd0);
        check_value("dec_valid", 32'(dec_valid), 32'd0);
        @(posedge rst_n);
        check_value("wb_req.cyc", 32'(wb_req.cyc), 32'd0);
        check_value("dec_valid", 32'(dec_valid), 32'd0);
        // the first edge after release starts the read at the reset address
        next_cycle();
        check_value("wb_req.cyc", 32'(wb_req.cyc), 32'd1);
        check_value("wb_req.stb", 32'(wb_req.stb), 32'd1);
        check_value("wb_req.adr", wb_req.adr, RESET_PC);
        check_value("dec_valid", 32'(dec_valid), 32'd0);

        // sequential stream with the decode port always ready
        dec_ready = 1'b1;
        wait_words(N_SEQ);
        if (n_reg == 0 || n_imm == 0 || n_br == 0) begin
            errors++;
            $display("stream missed a format: %0d register, %0d immediate, %0d branch words",
                     n_reg, n_imm, n_br);
        end

        // random back-pressure on the decode port
        while (n_dec < N_SEQ + N_RAND) begin
            dec_ready = 1'($urandom_range(1, 0));
            next_cycle();
        end

        // the redirect empties the pipe, and with the output held the queue then fills
        dec_ready = 1'b0;
        send_redirect(STALL_PC);
        base = n_dec;
        repeat (100) next_cycle();
        check_value("stall_acks", stall_acks, QUEUE_DEPTH + 1);
        check_value("wb_req.cyc", 32'(wb_req.cyc), 32'd0);
        dec_ready = 1'b1;
        wait_words(base + QUEUE_DEPTH + 1);

        // each redirect lands while a read is on the bus
        for (int k = 0; k < N_REDIR; k++) begin
            while (!wb_req.cyc) begin
                next_cycle();
            end
            send_redirect(32'h0000_8000 + 32'(k) * 32'h124);
            wait_words(n_dec + N_AFTER);
        end

        $display("errors: %0d, decoded words: %0d", errors, n_dec);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // watchdog sized from the number of words the phases decode
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        errors++;
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("errors: %0d, decoded words: %0d", errors, n_dec);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* bench/wb_memory_model.sv */
`timescale 1ns/100ps

module wb_memory_model (
    input  logic               clk,
    input  logic               rst_n,
    input  fetch_pkg::wb_req_t wb_req,
    output fetch_pkg::wb_rsp_t wb_rsp
);

    // wait states still to go before the current read is acked
    logic [1:0] wait_left;
    // set once a read has been seen and its wait count drawn
    logic       pending;

    // the opcode field walks through all 64 values over 64 consecutive words
    // the other bits are a multiplicative hash so register fields vary too
    function automatic logic [31:0] mem_word(fetch_pkg::addr_t adr);
        logic [31:0] mix;
        mix = (adr * 32'h9e37_79b9) ^ {adr[15:0], adr[31:16]};
        return {adr[7:2] ^ adr[13:8], mix[25:0]};
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_rsp    <= '0;
            wait_left <= '0;
            pending   <= 1'b0;
        end else begin
            // ack is a single-cycle pulse
            wb_rsp.ack <= 1'b0;
            if (wb_req.cyc && wb_req.stb && !wb_rsp.ack) begin
                if (!pending) begin
                    pending   <= 1'b1;
                    wait_left <= 2'($urandom_range(3, 0));
                end else if (wait_left == 2'd0) begin
                    pending    <= 1'b0;
                    wb_rsp.ack <= 1'b1;
                    wb_rsp.dat <= mem_word(wb_req.adr);
                end else begin
                    wait_left <= wait_left - 2'd1;
                end
            end
        end
    end

endmodule

/* compile.f */
hw/isa_pkg.sv
hw/fetch_pkg.sv
hw/fetch_queue.sv
hw/wb_fetch_master.sv
hw/predecoder.sv
hw/fetch_unit_top.sv
bench/tb_clock.sv
bench/wb_memory_model.sv
bench/tb_fetch_unit.sv

/* hw/fetch_pkg.sv */
package fetch_pkg;

    // byte address on the fetch path
    typedef logic [31:0] addr_t;

    // every instruction is one 32-bit word, so addresses step by four bytes
    localparam addr_t INSTR_BYTES = 32'd4;

    // one queue slot pairs the fetch address with the word that came back
    typedef struct packed {
        addr_t          pc;
        isa_pkg::instr_u instr;
    } queue_entry_t;

    // master side of a classic Wishbone read
    // cyc and stb always move together here since only single reads occur
    typedef struct packed {
        logic  cyc;
        logic  stb;
        addr_t adr;
    } wb_req_t;

    // slave side of the read
    // dat is only meaningful in the cycle where ack is high
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

/* hw/fetch_queue.sv */
`timescale 1ns/100ps

module fetch_queue #(
    parameter int unsigned QUEUE_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    enq_valid,
    output logic                    enq_ready,
    input  fetch_pkg::queue_entry_t enq_entry,
    output logic                    deq_valid,
    input  logic                    deq_ready,
    output fetch_pkg::queue_entry_t deq_entry
);

    // the counters carry one extra bit so that full and empty differ
    localparam int unsigned IDX_W = $clog2(QUEUE_DEPTH);
    localparam int unsigned CTR_W = IDX_W + 1;

    logic [CTR_W-1:0] enq_ctr;
    logic [CTR_W-1:0] deq_ctr;
    logic [IDX_W-1:0] enq_idx;
    logic [IDX_W-1:0] deq_idx;
    logic             idx_equal;
    logic             wrap_equal;
    logic             enq_fire;
    logic             deq_fire;
    logic [QUEUE_DEPTH-1:0] wr_sel;

    // storage for the entries themselves
    fetch_pkg::queue_entry_t slots [QUEUE_DEPTH];

    // the low counter bits index the storage
    assign enq_idx = enq_ctr[IDX_W-1:0];
    assign deq_idx = deq_ctr[IDX_W-1:0];

    // same slot with the same wrap bit is empty, with opposite wrap bits it is full
    assign idx_equal  = (enq_idx == deq_idx);
    assign wrap_equal = (enq_ctr[CTR_W-1] == deq_ctr[CTR_W-1]);
    assign enq_ready  = !(idx_equal && !wrap_equal);
    assign deq_valid  = !(idx_equal && wrap_equal);

    // a handshake happens on each side where valid meets ready
    assign enq_fire = enq_valid && enq_ready;
    assign deq_fire = deq_valid && deq_ready;

    // flush wins over both handshakes and returns the queue to empty
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enq_ctr <= '0;
            deq_ctr <= '0;
        end else if (flush) begin
            enq_ctr <= '0;
            deq_ctr <= '0;
        end else begin
            if (enq_fire) begin
                enq_ctr <= enq_ctr + CTR_W'(1);
            end
            if (deq_fire) begin
                deq_ctr <= deq_ctr + CTR_W'(1);
            end
        end
    end

    // one-hot write select decoded from the enqueue index
    assign wr_sel = enq_fire ? (QUEUE_DEPTH'(1) << enq_idx) : '0;

    // each slot loads only when its select bit is set
    for (genvar i = 0; i < QUEUE_DEPTH; i++) begin : g_slot
        always_ff @(posedge clk) begin
            if (wr_sel[i]) begin
                slots[i] <= enq_entry;
            end
        end
    end

    // the head is read straight through the dequeue index
    assign deq_entry = slots[deq_idx];

endmodule

/* hw/fetch_unit_top.sv */
`timescale 1ns/100ps

module fetch_unit_top #(
    parameter int unsigned      QUEUE_DEPTH = 8,
    parameter fetch_pkg::addr_t RESET_PC    = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               rst_n,
    output fetch_pkg::wb_req_t wb_req,
    input  fetch_pkg::wb_rsp_t wb_rsp,
    input  logic               redirect_valid,
    input  fetch_pkg::addr_t   redirect_pc,
    output logic               dec_valid,
    output isa_pkg::decoded_t  dec,
    input  logic               dec_ready
);

    // master to queue
    logic                    enq_valid;
    logic                    enq_ready;
    fetch_pkg::queue_entry_t enq_entry;
    // queue to predecoder
    logic                    deq_valid;
    logic                    deq_ready;
    fetch_pkg::queue_entry_t deq_entry;

    // the bus side fetches words and pushes them with their addresses
    wb_fetch_master #(
        .RESET_PC(RESET_PC)
    ) i_master (
        .clk           (clk),
        .rst_n         (rst_n),
        .redirect_valid(redirect_valid),
        .redirect_pc   (redirect_pc),
        .wb_req        (wb_req),
        .wb_rsp        (wb_rsp),
        .enq_ready     (enq_ready),
        .enq_valid     (enq_valid),
        .enq_entry     (enq_entry)
    );

    // redirect doubles as the flush for the queue and the predecoder
    fetch_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) i_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (redirect_valid),
        .enq_valid(enq_valid),
        .enq_ready(enq_ready),
        .enq_entry(enq_entry),
        .deq_valid(deq_valid),
        .deq_ready(deq_ready),
        .deq_entry(deq_entry)
    );

    predecoder i_predecoder (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (redirect_valid),
        .deq_valid(deq_valid),
        .deq_ready(deq_ready),
        .deq_entry(deq_entry),
        .dec_valid(dec_valid),
        .dec_ready(dec_ready),
        .dec      (dec)
    );

endmodule

/* hw/isa_pkg.sv */
package isa_pkg;

    // the opcode sits in the top six bits of every instruction word
    typedef logic [5:0] opcode_t;

    // opcode bit 5 picks the format, clear for register and set for immediate
    localparam int unsigned OPC_FMT_BIT = 5;
    // with bit 5 set, bit 4 marks the immediate-format word as a branch
    localparam int unsigned OPC_BR_BIT = 4;

    // register format with two sources and an eleven bit function field
    typedef struct packed {
        opcode_t     opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [10:0] funct;
    } r_fmt_t;

    // immediate format, where the low sixteen bits carry a signed immediate
    typedef struct packed {
        opcode_t     opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [15:0] imm;
    } i_fmt_t;

    // one fetched word, read through whichever view its opcode calls for
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    // the predecoded instruction as the next stage sees it
    typedef struct packed {
        logic [31:0] pc;
        opcode_t     opcode;
        logic        is_imm;
        logic        is_branch;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [10:0] funct;
        logic [31:0] imm;
        // low word bits kept for debug
        logic [22:0] raw;
    } decoded_t;

    // true for the immediate class, which includes branches
    function automatic logic is_imm_op(opcode_t op);
        return op[OPC_FMT_BIT];
    endfunction

    // a branch needs both the format bit and the branch bit
    function automatic logic is_branch_op(opcode_t op);
        return op[OPC_FMT_BIT] & op[OPC_BR_BIT];
    endfunction

endpackage

/* hw/predecoder.sv */
`timescale 1ns/100ps

module predecoder (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    deq_valid,
    output logic                    deq_ready,
    input  fetch_pkg::queue_entry_t deq_entry,
    output logic                    dec_valid,
    input  logic                    dec_ready,
    output isa_pkg::decoded_t       dec
);

    isa_pkg::instr_u   word;
    isa_pkg::decoded_t next_dec;
    logic              load;

    assign word = deq_entry.instr;

    // split the head word by format
    // the opcode, rd and rs1 lie in the same bits in both views, so the r view reads them
    always_comb begin
        next_dec.pc        = deq_entry.pc;
        next_dec.opcode    = word.r.opcode;
        next_dec.is_imm    = isa_pkg::is_imm_op(word.r.opcode);
        next_dec.is_branch = isa_pkg::is_branch_op(word.r.opcode);
        next_dec.rd        = word.r.rd;
        next_dec.rs1       = word.r.rs1;
        next_dec.raw       = word[22:0];
        if (next_dec.is_imm) begin
            // immediate format has no second source and no function field
            next_dec.rs2   = '0;
            next_dec.funct = '0;
            next_dec.imm   = {{16{word.i.imm[15]}}, word.i.imm};
        end else begin
            next_dec.rs2   = word.r.rs2;
            next_dec.funct = word.r.funct;
            next_dec.imm   = '0;
        end
    end

    // the output register takes a new word when it is empty or being drained
    assign load      = !dec_valid || dec_ready;
    assign deq_ready = load;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (flush) begin
            // the queue empties at the same edge, so nothing old survives
            dec_valid <= 1'b0;
        end else if (load) begin
            dec_valid <= deq_valid;
        end
    end

    // payload only moves when a real word is taken from the queue
    always_ff @(posedge clk) begin
        if (load && deq_valid) begin
            dec <= next_dec;
        end
    end

endmodule

/* hw/wb_fetch_master.sv */
`timescale 1ns/100ps

module wb_fetch_master #(
    parameter fetch_pkg::addr_t RESET_PC = 32'h0000_0000
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    redirect_valid,
    input  fetch_pkg::addr_t        redirect_pc,
    output fetch_pkg::wb_req_t      wb_req,
    input  fetch_pkg::wb_rsp_t      wb_rsp,
    input  logic                    enq_ready,
    output logic                    enq_valid,
    output fetch_pkg::queue_entry_t enq_entry
);

    typedef enum logic {
        IDLE,
        BUSY
    } state_t;

    state_t           state;
    // next address to fetch
    fetch_pkg::addr_t pc;
    // address of the read currently on the bus, held stable until ack
    fetch_pkg::addr_t req_adr;
    // marks an in-flight read whose word belongs to the old stream
    logic             discard;
    logic             ack_seen;
    logic             push;

    assign ack_seen = (state == BUSY) && wb_rsp.ack;

    // a word goes to the queue unless it is stale or a redirect lands in the ack cycle
    assign push = ack_seen && !discard && !redirect_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            pc      <= RESET_PC;
            req_adr <= RESET_PC;
            discard <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (redirect_valid) begin
                        pc <= redirect_pc;
                    end else if (enq_ready) begin
                        // only this master writes the queue, so the free slot stays free
                        state   <= BUSY;
                        req_adr <= pc;
                    end
                end
                BUSY: begin
                    if (wb_rsp.ack) begin
                        // always drop back to idle for at least one cycle after ack
                        state   <= IDLE;
                        discard <= 1'b0;
                    end else if (redirect_valid) begin
                        discard <= 1'b1;
                    end
                    if (redirect_valid) begin
                        pc <= redirect_pc;
                    end else if (push) begin
                        pc <= req_adr + fetch_pkg::INSTR_BYTES;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // cyc and stb stay up for the whole busy state, which ends at ack
    always_comb begin
        wb_req.cyc = (state == BUSY);
        wb_req.stb = (state == BUSY);
        wb_req.adr = req_adr;
    end

    // the returned data word is taken as an instruction tagged with its address
    always_comb begin
        enq_valid       = push;
        enq_entry.pc    = req_adr;
        enq_entry.instr = isa_pkg::instr_u'(wb_rsp.dat);
    end

endmodule
